//--- Makefile
# Verilator build and run of the debug slice testbench

VERILATOR ?= verilator
TOP       ?= dfdTb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= All tests passed!

.PHONY: help build test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS PASS_MSG"

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- flist.f
+incdir+src
src/dfdPkg.sv
src/dfdApbRegs.sv
src/dfdDebugMux.sv
src/dfdSignalMatch.sv
src/dfdClaSequencer.sv
src/dfdTimeSync.sv
src/dfdTraceBuffer.sv
src/dfdTop.sv
verif/dfdTop_checker.sv
verif/dfdScoreboard.sv
verif/dfdTb.sv

//--- src/dfdApbRegs.sv
// APB slave of the debug slice holding configuration registers and the status read mux
`timescale 1ns/1ps
`include "dfd_cfg.svh"

module dfdApbRegs (
  input  logic                                                 clk,
  input  logic                                                 i_reset,
  input  dfdPkg::apbReq_t                                      i_apbReq,
  output dfdPkg::apbRsp_t                                      o_apbRsp,
  output logic [1:0][`DFD_LANE_SEL_WIDTH-1:0]                  o_laneSel,
  output dfdPkg::claCfg_t                                      o_claCfg,
  output logic [`DFD_TS_WIDTH-1:0]                             o_tsPreset,
  output dfdPkg::traceCtl_t                                    o_traceCtl,
  input  dfdPkg::claState_e                                    i_claState,
  input  logic [`DFD_TS_WIDTH-1:0]                             i_timestamp,
  input  logic [`DFD_TRACE_PTR_WIDTH-1:0]                      i_traceWrPtr,
  input  logic                                                 i_traceEn,
  input  logic [`DFD_TRACE_DEPTH-1:0][`DFD_BUS_WIDTH-1:0]      i_traceData
);
  import dfdPkg::*;

  localparam int DataW = `DFD_APB_DATA_WIDTH;
  localparam logic [`DFD_APB_ADDR_WIDTH-1:0] TraceEnd =
    `DFD_TRACE_BASE + `DFD_APB_ADDR_WIDTH'(4 * `DFD_TRACE_DEPTH);

  logic                               access;
  logic                               wrAcc;
  logic                               addrHit;
  logic                               roHit;
  logic                               traceHit;
  logic [`DFD_APB_ADDR_WIDTH-1:0]     traceOff;
  logic [`DFD_TRACE_PTR_WIDTH-1:0]    traceIdx;
  logic [DataW-1:0]                   rdData;

  assign access   = i_apbReq.psel && i_apbReq.penable;
  assign wrAcc    = access && i_apbReq.pwrite;
  assign traceOff = i_apbReq.paddr - `DFD_TRACE_BASE;
  assign traceIdx = traceOff[2 +: `DFD_TRACE_PTR_WIDTH];
  assign traceHit = (i_apbReq.paddr >= `DFD_TRACE_BASE) && (i_apbReq.paddr < TraceEnd) &&
                    (i_apbReq.paddr[1:0] == 2'b00);

  // ********************************************************************
  // Writable registers
  // ********************************************************************
  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_laneSel  <= '0;
      o_claCfg   <= '0;
      o_tsPreset <= '0;
    end else if (wrAcc) begin
      case (i_apbReq.paddr)
        `DFD_REG_MUXSEL:   o_laneSel <= i_apbReq.pwdata[7:0];
        `DFD_REG_MASK0:    o_claCfg.mask0 <= i_apbReq.pwdata;
        `DFD_REG_MATCH0:   o_claCfg.match0 <= i_apbReq.pwdata;
        `DFD_REG_MASK1:    o_claCfg.mask1 <= i_apbReq.pwdata;
        `DFD_REG_MATCH1:   o_claCfg.match1 <= i_apbReq.pwdata;
        `DFD_REG_CLACTRL: begin
          o_claCfg.arm    <= i_apbReq.pwdata[0];
          o_claCfg.action <= claAction_e'(i_apbReq.pwdata[3:1]);
        end
        `DFD_REG_TSPRESET: o_tsPreset <= i_apbReq.pwdata;
        default: ;
      endcase
    end
  end

  // Trace enable lives in the trace buffer, only strobe it here
  always_comb begin
    o_traceCtl.wrStb = wrAcc && (i_apbReq.paddr == `DFD_REG_TRACECTRL);
    o_traceCtl.en    = i_apbReq.pwdata[0];
  end

  // ********************************************************************
  // Read mux and error response
  // ********************************************************************
  always_comb begin
    rdData  = '0;
    addrHit = 1'b1;
    roHit   = 1'b0;
    case (i_apbReq.paddr)
      `DFD_REG_MUXSEL:    rdData = DataW'(o_laneSel);
      `DFD_REG_MASK0:     rdData = o_claCfg.mask0;
      `DFD_REG_MATCH0:    rdData = o_claCfg.match0;
      `DFD_REG_MASK1:     rdData = o_claCfg.mask1;
      `DFD_REG_MATCH1:    rdData = o_claCfg.match1;
      `DFD_REG_CLACTRL:   rdData = DataW'({o_claCfg.action, o_claCfg.arm});
      `DFD_REG_TSPRESET:  rdData = o_tsPreset;
      `DFD_REG_TRACECTRL: rdData = DataW'({i_traceWrPtr, 7'd0, i_traceEn});
      `DFD_REG_CLASTATUS: begin
        rdData = DataW'(i_claState);
        roHit  = 1'b1;
      end
      `DFD_REG_TIMESTAMP: begin
        rdData = i_timestamp;
        roHit  = 1'b1;
      end
      default: begin
        if (traceHit) begin
          rdData = i_traceData[traceIdx];
          roHit  = 1'b1;
        end else begin
          addrHit = 1'b0;
        end
      end
    endcase
  end

  always_comb begin
    o_apbRsp.pready  = 1'b1;
    o_apbRsp.prdata  = (access && !i_apbReq.pwrite) ? rdData : '0;
    o_apbRsp.pslverr = access && (!addrHit || (i_apbReq.pwrite && roHit));
  end

endmodule

//--- src/dfdClaSequencer.sv
// Two-stage trigger FSM of the logic analyzer and its one-shot action decode
`timescale 1ns/1ps

module dfdClaSequencer (
  input  logic                clk,
  input  logic                i_reset,
  input  dfdPkg::claCfg_t     i_claCfg,
  input  logic [1:0]          i_match,
  output dfdPkg::claState_e   o_state,
  output dfdPkg::claActions_t o_actions
);
  import dfdPkg::*;

  claState_e   stateNext;
  claActions_t actNext;
  logic        enterTrig;

  // ********************************************************************
  // Trigger FSM
  // ********************************************************************
  always_comb begin
    stateNext = o_state;
    if (!i_claCfg.arm) begin
      stateNext = CLA_IDLE;
    end else begin
      case (o_state)
        CLA_IDLE:      stateNext = CLA_STAGE1;
        CLA_STAGE1:    if (i_match[0]) stateNext = CLA_STAGE2;
        CLA_STAGE2:    if (i_match[1]) stateNext = CLA_TRIGGERED;
        CLA_TRIGGERED: stateNext = CLA_TRIGGERED;
        default:       stateNext = CLA_IDLE;
      endcase
    end
  end

  assign enterTrig = (stateNext == CLA_TRIGGERED) && (o_state != CLA_TRIGGERED);

  // Pulse lines up with the first triggered cycle
  always_comb begin
    actNext = '0;
    if (enterTrig) begin
      case (i_claCfg.action)
        ACT_TRACE_START: actNext.traceStart     = 1'b1;
        ACT_TRACE_STOP:  actNext.traceStop      = 1'b1;
        ACT_HALT:        actNext.haltClock      = 1'b1;
        ACT_INTERRUPT:   actNext.debugInterrupt = 1'b1;
        ACT_XTRIGGER:    actNext.xtriggerOut    = 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_state   <= CLA_IDLE;
      o_actions <= '0;
    end else begin
      o_state   <= stateNext;
      o_actions <= actNext;
    end
  end

endmodule

//--- src/dfdDebugMux.sv
// Debug-bus multiplexer picking two hardware lanes into the registered debug bus
`timescale 1ns/1ps
`include "dfd_cfg.svh"

module dfdDebugMux (
  input  logic                                clk,
  input  logic                                i_reset,
  input  dfdPkg::laneArray_t                  i_hwLanes,
  input  logic [1:0][`DFD_LANE_SEL_WIDTH-1:0] i_laneSel,
  output logic [`DFD_BUS_WIDTH-1:0]           o_debugBus
);

  logic [`DFD_LANE_WIDTH-1:0] laneLo;
  logic [`DFD_LANE_WIDTH-1:0] laneHi;

  // Lane 0 select feeds the low half
  assign laneLo = i_hwLanes[i_laneSel[0]];
  assign laneHi = i_hwLanes[i_laneSel[1]];

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_debugBus <= '0;
    end else begin
      o_debugBus <= {laneHi, laneLo};
    end
  end

endmodule

//--- src/dfdPkg.sv
// Structs and enums shared by the debug slice RTL and its testbench, imported where used
`include "dfd_cfg.svh"

package dfdPkg;

  // ********************************************************************
  // APB
  // ********************************************************************
  typedef struct packed {
    logic [`DFD_APB_ADDR_WIDTH-1:0] paddr;
    logic                           psel;
    logic                           penable;
    logic                           pwrite;
    logic [`DFD_APB_DATA_WIDTH-1:0] pwdata;
  } apbReq_t;

  typedef struct packed {
    logic                           pready;
    logic [`DFD_APB_DATA_WIDTH-1:0] prdata;
    logic                           pslverr;
  } apbRsp_t;

  // ********************************************************************
  // Logic analyzer
  // ********************************************************************
  typedef enum logic [1:0] {
    CLA_IDLE      = 2'd0,
    CLA_STAGE1    = 2'd1,
    CLA_STAGE2    = 2'd2,
    CLA_TRIGGERED = 2'd3
  } claState_e;

  typedef enum logic [2:0] {
    ACT_NONE        = 3'd0,
    ACT_TRACE_START = 3'd1,
    ACT_TRACE_STOP  = 3'd2,
    ACT_HALT        = 3'd3,
    ACT_INTERRUPT   = 3'd4,
    ACT_XTRIGGER    = 3'd5
  } claAction_e;

  typedef struct packed {
    logic [`DFD_BUS_WIDTH-1:0] mask0;
    logic [`DFD_BUS_WIDTH-1:0] match0;
    logic [`DFD_BUS_WIDTH-1:0] mask1;
    logic [`DFD_BUS_WIDTH-1:0] match1;
    logic                      arm;
    claAction_e                action;
  } claCfg_t;

  // One pulse per action
  typedef struct packed {
    logic traceStart;
    logic traceStop;
    logic haltClock;
    logic debugInterrupt;
    logic xtriggerOut;
  } claActions_t;

  typedef struct packed {
    logic wrStb;
    logic en;
  } traceCtl_t;

  typedef logic [`DFD_NUM_LANES-1:0][`DFD_LANE_WIDTH-1:0] laneArray_t;

endpackage

//--- src/dfdSignalMatch.sv
// Mask/match comparators on the debug bus, one per trigger stage of the sequencer
`timescale 1ns/1ps
`include "dfd_cfg.svh"

module dfdSignalMatch (
  input  logic [`DFD_BUS_WIDTH-1:0] i_debugBus,
  input  dfdPkg::claCfg_t           i_claCfg,
  output logic [1:0]                o_match
);

  logic [1:0][`DFD_BUS_WIDTH-1:0] mask;
  logic [1:0][`DFD_BUS_WIDTH-1:0] match;

  assign mask  = {i_claCfg.mask1, i_claCfg.mask0};
  assign match = {i_claCfg.match1, i_claCfg.match0};

  // Bits outside the mask never block a hit
  for (genvar k = 0; k < 2; k++) begin : gMatch
    assign o_match[k] = ((i_debugBus & mask[k]) == (match[k] & mask[k]));
  end

endmodule

//--- src/dfdTimeSync.sv
// Timestamp counter advanced by the time tick and preset by the cross-trigger input
`timescale 1ns/1ps
`include "dfd_cfg.svh"

module dfdTimeSync (
  input  logic                     clk,
  input  logic                     i_reset,
  input  logic                     i_timeTick,
  input  logic                     i_xtriggerIn,
  input  logic [`DFD_TS_WIDTH-1:0] i_tsPreset,
  output logic [`DFD_TS_WIDTH-1:0] o_timestamp
);

  // Preset has priority over the tick
  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_timestamp <= '0;
    end else if (i_xtriggerIn) begin
      o_timestamp <= i_tsPreset;
    end else if (i_timeTick) begin
      o_timestamp <= o_timestamp + 1'b1;
    end
  end

endmodule

//--- src/dfdTop.sv
// Top of the debug slice joining APB registers, debug mux, analyzer, time sync and trace
`timescale 1ns/1ps
`include "dfd_cfg.svh"

module dfdTop (
  input  logic                     clk,
  input  logic                     i_reset,
  input  dfdPkg::apbReq_t          i_apbReq,
  output dfdPkg::apbRsp_t          o_apbRsp,
  input  dfdPkg::laneArray_t       i_hwLanes,
  input  logic                     i_timeTick,
  input  logic                     i_xtriggerIn,
  output dfdPkg::claActions_t      o_actions,
  output logic [`DFD_TS_WIDTH-1:0] o_timestamp
);
  import dfdPkg::*;

  logic [1:0][`DFD_LANE_SEL_WIDTH-1:0]             laneSel;
  claCfg_t                                         claCfg;
  traceCtl_t                                       traceCtl;
  claState_e                                       claState;
  logic [`DFD_TS_WIDTH-1:0]                        tsPreset;
  logic [`DFD_BUS_WIDTH-1:0]                       debugBus;
  logic [1:0]                                      match;
  logic                                            traceEn;
  logic [`DFD_TRACE_PTR_WIDTH-1:0]                 traceWrPtr;
  logic [`DFD_TRACE_DEPTH-1:0][`DFD_BUS_WIDTH-1:0] traceData;

  dfdApbRegs regs_i (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_apbReq     (i_apbReq),
    .o_apbRsp     (o_apbRsp),
    .o_laneSel    (laneSel),
    .o_claCfg     (claCfg),
    .o_tsPreset   (tsPreset),
    .o_traceCtl   (traceCtl),
    .i_claState   (claState),
    .i_timestamp  (o_timestamp),
    .i_traceWrPtr (traceWrPtr),
    .i_traceEn    (traceEn),
    .i_traceData  (traceData)
  );

  dfdDebugMux mux_i (
    .clk        (clk),
    .i_reset    (i_reset),
    .i_hwLanes  (i_hwLanes),
    .i_laneSel  (laneSel),
    .o_debugBus (debugBus)
  );

  dfdSignalMatch match_i (
    .i_debugBus (debugBus),
    .i_claCfg   (claCfg),
    .o_match    (match)
  );

  dfdClaSequencer seq_i (
    .clk       (clk),
    .i_reset   (i_reset),
    .i_claCfg  (claCfg),
    .i_match   (match),
    .o_state   (claState),
    .o_actions (o_actions)
  );

  dfdTimeSync tsync_i (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_timeTick   (i_timeTick),
    .i_xtriggerIn (i_xtriggerIn),
    .i_tsPreset   (tsPreset),
    .o_timestamp  (o_timestamp)
  );

  dfdTraceBuffer trace_i (
    .clk        (clk),
    .i_reset    (i_reset),
    .i_debugBus (debugBus),
    .i_traceCtl (traceCtl),
    .i_actions  (o_actions),
    .o_traceEn  (traceEn),
    .o_wrPtr    (traceWrPtr),
    .o_entries  (traceData)
  );

endmodule

//--- src/dfdTraceBuffer.sv
// Change-detected capture of the debug bus into a small circular trace store
`timescale 1ns/1ps
`include "dfd_cfg.svh"

module dfdTraceBuffer (
  input  logic                                            clk,
  input  logic                                            i_reset,
  input  logic [`DFD_BUS_WIDTH-1:0]                       i_debugBus,
  input  dfdPkg::traceCtl_t                               i_traceCtl,
  input  dfdPkg::claActions_t                             i_actions,
  output logic                                            o_traceEn,
  output logic [`DFD_TRACE_PTR_WIDTH-1:0]                 o_wrPtr,
  output logic [`DFD_TRACE_DEPTH-1:0][`DFD_BUS_WIDTH-1:0] o_entries
);

  logic [`DFD_BUS_WIDTH-1:0] prevBus;
  logic                      capture;

  assign capture = o_traceEn && (i_debugBus != prevBus);

  // ********************************************************************
  // Trace enable
  // ********************************************************************
  // Action pulses take priority over a register write
  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_traceEn <= 1'b0;
    end else if (i_actions.traceStart) begin
      o_traceEn <= 1'b1;
    end else if (i_actions.traceStop) begin
      o_traceEn <= 1'b0;
    end else if (i_traceCtl.wrStb) begin
      o_traceEn <= i_traceCtl.en;
    end
  end

  // ********************************************************************
  // Sample store
  // ********************************************************************
  always_ff @(posedge clk) begin
    if (i_reset) begin
      prevBus   <= '0;
      o_wrPtr   <= '0;
      o_entries <= '0;
    end else begin
      prevBus <= i_debugBus;
      if (capture) begin
        o_entries[o_wrPtr] <= i_debugBus;
        // Wraps naturally at depth 16
        o_wrPtr <= o_wrPtr + 1'b1;
      end
    end
  end

endmodule

//--- src/dfd_cfg.svh
// Widths, depths and APB register map of the debug slice, included by RTL and testbench
`ifndef DFD_CFG_SVH
`define DFD_CFG_SVH

`define DFD_LANE_WIDTH      16
`define DFD_NUM_LANES       16
`define DFD_LANE_SEL_WIDTH  4
`define DFD_BUS_WIDTH       32
`define DFD_APB_ADDR_WIDTH  12
`define DFD_APB_DATA_WIDTH  32
`define DFD_TS_WIDTH        32
`define DFD_TRACE_DEPTH     16
`define DFD_TRACE_PTR_WIDTH 4

// Word-aligned register offsets
`define DFD_REG_MUXSEL    12'h000
`define DFD_REG_MASK0     12'h004
`define DFD_REG_MATCH0    12'h008
`define DFD_REG_MASK1     12'h00C
`define DFD_REG_MATCH1    12'h010
`define DFD_REG_CLACTRL   12'h014
`define DFD_REG_CLASTATUS 12'h018
`define DFD_REG_TSPRESET  12'h01C
`define DFD_REG_TIMESTAMP 12'h020
`define DFD_REG_TRACECTRL 12'h024
`define DFD_TRACE_BASE    12'h040

`endif

//--- verif/dfdScoreboard.sv
// Cycle model of the debug slice, compares actions, timestamp and APB read responses
`timescale 1ns/1ps
`include "dfd_cfg.svh"

module dfdScoreboard (
  input  logic                     clk,
  input  logic                     i_reset,
  input  dfdPkg::apbReq_t          i_apbReq,
  input  dfdPkg::apbRsp_t          i_apbRsp,
  input  dfdPkg::laneArray_t       i_hwLanes,
  input  logic                     i_timeTick,
  input  logic                     i_xtriggerIn,
  input  dfdPkg::claActions_t      i_actions,
  input  logic [`DFD_TS_WIDTH-1:0] i_timestamp,
  output int                       o_errCount
);
  import dfdPkg::*;

  // mask0, match0, mask1, match1
  logic [31:0] cfgReg [4];
  logic [7:0]  laneSel;
  logic        arm;
  logic [2:0]  action;
  logic [31:0] tsPreset;
  logic [31:0] ts;
  logic [31:0] bus;
  logic [31:0] prevBus;
  claState_e   mState;
  logic [4:0]  acts;
  logic        traceEn;
  logic [3:0]  wrPtr;
  logic [31:0] entries [16];
  int          errCount = 0;

  assign o_errCount = errCount;

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
      errCount++;
    end
  endtask

  task automatic resetModel();
    foreach (cfgReg[i]) cfgReg[i] = '0;
    foreach (entries[i]) entries[i] = '0;
    laneSel  = '0;
    arm      = 1'b0;
    action   = '0;
    tsPreset = '0;
    ts       = '0;
    bus      = '0;
    prevBus  = '0;
    mState   = CLA_IDLE;
    acts     = '0;
    traceEn  = 1'b0;
    wrPtr    = '0;
  endtask

  function automatic void decodeRead(input logic [11:0] addr, output logic [31:0] data,
                                     output logic mapped, output logic readOnly);
    data     = '0;
    mapped   = 1'b1;
    readOnly = 1'b0;
    if (addr >= `DFD_TRACE_BASE && addr < `DFD_TRACE_BASE + 12'h040 && addr[1:0] == 2'b00) begin
      data     = entries[addr[5:2]];
      readOnly = 1'b1;
    end else begin
      case (addr)
        `DFD_REG_MUXSEL:    data = {24'd0, laneSel};
        `DFD_REG_MASK0:     data = cfgReg[0];
        `DFD_REG_MATCH0:    data = cfgReg[1];
        `DFD_REG_MASK1:     data = cfgReg[2];
        `DFD_REG_MATCH1:    data = cfgReg[3];
        `DFD_REG_CLACTRL:   data = {28'd0, action, arm};
        `DFD_REG_TSPRESET:  data = tsPreset;
        `DFD_REG_TRACECTRL: data = {20'd0, wrPtr, 7'd0, traceEn};
        `DFD_REG_CLASTATUS: begin
          data     = {30'd0, mState};
          readOnly = 1'b1;
        end
        `DFD_REG_TIMESTAMP: begin
          data     = ts;
          readOnly = 1'b1;
        end
        default: mapped = 1'b0;
      endcase
    end
  endfunction

  // ********************************************************************
  // One clock edge of the slice, all terms from pre-edge values
  // ********************************************************************
  task automatic stepModel(input logic wrAcc);
    logic [1:0] hit;
    claState_e  stNext;
    hit[0] = (bus & cfgReg[0]) == (cfgReg[1] & cfgReg[0]);
    hit[1] = (bus & cfgReg[2]) == (cfgReg[3] & cfgReg[2]);
    if (traceEn && bus != prevBus) begin
      entries[wrPtr] = bus;
      wrPtr          = wrPtr + 4'd1;
    end
    prevBus = bus;
    if (acts[4]) begin
      traceEn = 1'b1;
    end else if (acts[3]) begin
      traceEn = 1'b0;
    end else if (wrAcc && i_apbReq.paddr == `DFD_REG_TRACECTRL) begin
      traceEn = i_apbReq.pwdata[0];
    end
    stNext = mState;
    if (!arm) begin
      stNext = CLA_IDLE;
    end else begin
      case (mState)
        CLA_IDLE:   stNext = CLA_STAGE1;
        CLA_STAGE1: stNext = hit[0] ? CLA_STAGE2 : CLA_STAGE1;
        CLA_STAGE2: stNext = hit[1] ? CLA_TRIGGERED : CLA_STAGE2;
        default:    stNext = CLA_TRIGGERED;
      endcase
    end
    acts = '0;
    if (stNext == CLA_TRIGGERED && mState != CLA_TRIGGERED && action >= 3'd1 && action <= 3'd5)
      acts = 5'b10000 >> (action - 3'd1);
    mState = stNext;
    if (i_xtriggerIn) begin
      ts = tsPreset;
    end else if (i_timeTick) begin
      ts = ts + 32'd1;
    end
    bus = {i_hwLanes[laneSel[7:4]], i_hwLanes[laneSel[3:0]]};
    if (wrAcc) begin
      case (i_apbReq.paddr)
        `DFD_REG_MUXSEL:   laneSel = i_apbReq.pwdata[7:0];
        `DFD_REG_MASK0:    cfgReg[0] = i_apbReq.pwdata;
        `DFD_REG_MATCH0:   cfgReg[1] = i_apbReq.pwdata;
        `DFD_REG_MASK1:    cfgReg[2] = i_apbReq.pwdata;
        `DFD_REG_MATCH1:   cfgReg[3] = i_apbReq.pwdata;
        `DFD_REG_TSPRESET: tsPreset = i_apbReq.pwdata;
        `DFD_REG_CLACTRL: begin
          arm    = i_apbReq.pwdata[0];
          action = i_apbReq.pwdata[3:1];
        end
        default: ;
      endcase
    end
  endtask

  always @(posedge clk) begin : compareStep
    logic [31:0] rdExp;
    logic        mapped;
    logic        readOnly;
    logic        expErr;
    logic        access;
    logic [4:0]  actBits;
    if (i_reset) begin
      resetModel();
    end else begin
      actBits = i_actions;
      checkValue("o_actions", 32'(actBits), 32'(acts));
      checkValue("o_timestamp", i_timestamp, ts);
      access = i_apbReq.psel && i_apbReq.penable;
      if (access) begin
        decodeRead(i_apbReq.paddr, rdExp, mapped, readOnly);
        expErr = !mapped || (i_apbReq.pwrite && readOnly);
        checkValue($sformatf("pslverr@%h", i_apbReq.paddr), 32'(i_apbRsp.pslverr),
                   32'(expErr));
        if (!i_apbReq.pwrite && !expErr)
          checkValue($sformatf("prdata@%h", i_apbReq.paddr), i_apbRsp.prdata, rdExp);
      end
      stepModel(access && i_apbReq.pwrite);
    end
  end

endmodule

//--- verif/dfdTb.sv
// Testbench top for the debug slice, drives random APB, lane, tick and cross-trigger stimulus
`timescale 1ns/1ps
`include "dfd_cfg.svh"

module dfdTb;
  import dfdPkg::*;

  localparam int ClkPeriod = 4;
  localparam int RegLoops  = 24;
  localparam int SeqLoops  = 24;
  localparam int TimeLoops = 16;
  localparam int TraceWait = 40;
  // Upper bound of APB accesses at two cycles each
  localparam int Accesses   = RegLoops * 4 + SeqLoops * 20 + TimeLoops * 2 + 60;
  localparam int StimCycles = 10 + 2 * Accesses + 3 * TraceWait;
  localparam int TimeoutNs  = (StimCycles + 200) * ClkPeriod;
  localparam logic [11:0] RwRegs [8] = '{`DFD_REG_MUXSEL, `DFD_REG_MASK0, `DFD_REG_MATCH0,
    `DFD_REG_MASK1, `DFD_REG_MATCH1, `DFD_REG_CLACTRL, `DFD_REG_TSPRESET, `DFD_REG_TRACECTRL};

  logic                     clk;
  logic                     reset;
  apbReq_t                  apbReq;
  apbRsp_t                  apbRsp;
  laneArray_t               hwLanes;
  logic                     timeTick;
  logic                     xtriggerIn;
  claActions_t              actions;
  logic [`DFD_TS_WIDTH-1:0] timestamp;
  logic                     streamOn;
  int                       errCount;

  dfdTop dut_i (
    .clk          (clk),
    .i_reset      (reset),
    .i_apbReq     (apbReq),
    .o_apbRsp     (apbRsp),
    .i_hwLanes    (hwLanes),
    .i_timeTick   (timeTick),
    .i_xtriggerIn (xtriggerIn),
    .o_actions    (actions),
    .o_timestamp  (timestamp)
  );

  dfdScoreboard sb_i (
    .clk          (clk),
    .i_reset      (reset),
    .i_apbReq     (apbReq),
    .i_apbRsp     (apbRsp),
    .i_hwLanes    (hwLanes),
    .i_timeTick   (timeTick),
    .i_xtriggerIn (xtriggerIn),
    .i_actions    (actions),
    .i_timestamp  (timestamp),
    .o_errCount   (errCount)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // Starts and ends on a falling edge
  task automatic apbAccess(input logic wr, input logic [11:0] addr, input logic [31:0] data);
    apbReq.paddr   = addr;
    apbReq.pwrite  = wr;
    apbReq.pwdata  = data;
    apbReq.psel    = 1'b1;
    apbReq.penable = 1'b0;
    @(negedge clk);
    apbReq.penable = 1'b1;
    @(posedge clk);
    while (!apbRsp.pready) @(posedge clk);
    @(negedge clk);
    apbReq.psel    = 1'b0;
    apbReq.penable = 1'b0;
  endtask

  task automatic apbWrite(input logic [11:0] addr, input logic [31:0] data);
    apbAccess(1'b1, addr, data);
  endtask

  task automatic apbRead(input logic [11:0] addr);
    apbAccess(1'b0, addr, 32'd0);
  endtask

  task automatic readTrace();
    apbRead(`DFD_REG_TRACECTRL);
    for (int k = 0; k < `DFD_TRACE_DEPTH; k++) apbRead(`DFD_TRACE_BASE + 12'(4 * k));
  endtask

  // Two set bits give frequent but not constant hits
  function automatic logic [31:0] sparseMask();
    return (32'd1 << ($urandom % 32)) | (32'd1 << ($urandom % 32));
  endfunction

  // Lane, tick and cross-trigger streams
  initial begin
    forever begin
      @(negedge clk);
      if (streamOn) begin
        timeTick   = 1'($urandom);
        xtriggerIn = ($urandom % 16) == 0;
        if (($urandom % 4) != 0)
          hwLanes = {$urandom, $urandom, $urandom, $urandom,
                     $urandom, $urandom, $urandom, $urandom};
      end
    end
  end

  initial begin
    #(TimeoutNs);
    $display("Timeout: the run did not finish within %0d ns", TimeoutNs);
    $display("Test failures found");
    $finish;
  end

  initial begin
    int          polls;
    int          failTotal;
    logic [2:0]  op;
    logic [11:0] addr;
    void'($urandom(9028));
    apbReq     = '0;
    hwLanes    = '0;
    timeTick   = 1'b0;
    xtriggerIn = 1'b0;
    streamOn   = 1'b0;
    reset      = 1'b1;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset    = 1'b0;
    streamOn = 1'b1;

    // ********************************************************************
    // Register readback and error responses
    // ********************************************************************
    for (int i = 0; i < RegLoops; i++) begin
      addr = RwRegs[i % 8];
      apbWrite(addr, $urandom);
      apbRead(addr);
      if (i % 2 == 0)
        apbRead(12'h028 + 12'(4 * ($urandom % 6)));
      else
        apbRead(12'h080 + 12'(4 * ($urandom % 992)));
      if (i % 3 == 0)
        apbWrite(`DFD_REG_CLASTATUS, $urandom);
      else if (i % 3 == 1)
        apbWrite(`DFD_REG_TIMESTAMP, $urandom);
      else
        apbWrite(`DFD_TRACE_BASE + 12'(4 * ($urandom % 16)), $urandom);
    end

    // ********************************************************************
    // Trigger sequencer over all opcodes with disarm from a random state
    // ********************************************************************
    for (int i = 0; i < SeqLoops; i++) begin
      op = 3'(i);
      apbWrite(`DFD_REG_MUXSEL, $urandom % 256);
      apbWrite(`DFD_REG_MASK0, sparseMask());
      apbWrite(`DFD_REG_MATCH0, $urandom);
      apbWrite(`DFD_REG_MASK1, sparseMask());
      apbWrite(`DFD_REG_MATCH1, $urandom);
      apbWrite(`DFD_REG_CLACTRL, {28'd0, op, 1'b1});
      polls = 1 + int'($urandom % 12);
      repeat (polls) apbRead(`DFD_REG_CLASTATUS);
      apbWrite(`DFD_REG_CLACTRL, {28'd0, op, 1'b0});
      apbRead(`DFD_REG_CLASTATUS);
    end

    // Preset and timestamp readback
    for (int i = 0; i < TimeLoops; i++) begin
      apbWrite(`DFD_REG_TSPRESET, $urandom);
      apbRead(`DFD_REG_TIMESTAMP);
    end

    // ********************************************************************
    // Trace capture by register, then by trigger start and stop
    // ********************************************************************
    apbWrite(`DFD_REG_TRACECTRL, 32'd1);
    repeat (TraceWait) @(negedge clk);
    readTrace();
    apbWrite(`DFD_REG_TRACECTRL, 32'd0);
    apbWrite(`DFD_REG_MASK0, 32'd0);
    apbWrite(`DFD_REG_MASK1, 32'd0);
    apbWrite(`DFD_REG_CLACTRL, 32'd0);
    apbWrite(`DFD_REG_CLACTRL, {28'd0, ACT_TRACE_START, 1'b1});
    repeat (TraceWait) @(negedge clk);
    readTrace();
    apbWrite(`DFD_REG_CLACTRL, 32'd0);
    apbWrite(`DFD_REG_CLACTRL, {28'd0, ACT_TRACE_STOP, 1'b1});
    repeat (TraceWait / 2) @(negedge clk);
    readTrace();

    streamOn = 1'b0;
    repeat (2) @(negedge clk);
    failTotal = errCount + dut_i.chk_i.failCount;
    $display("Closing: %0d scoreboard errors, %0d assertion failures",
             errCount, dut_i.chk_i.failCount);
    if (failTotal == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- verif/dfdTop_checker.sv
// Concurrent assertions on APB responses and action pulses, bound into the debug slice top
`timescale 1ns/1ps

module dfdTop_checker (
  input logic                clk,
  input logic                i_reset,
  input dfdPkg::apbReq_t     i_apbReq,
  input dfdPkg::apbRsp_t     i_apbRsp,
  input dfdPkg::claActions_t i_actions
);

  logic [4:0] act;
  int         failCount = 0;

  assign act = i_actions;

  apbReady: assert property (@(posedge clk) disable iff (i_reset) i_apbRsp.pready)
    else begin
      $error("pready dropped low");
      failCount++;
    end

  actOneHot: assert property (@(posedge clk) disable iff (i_reset) $onehot0(act))
    else begin
      $error("more than one action pulse high");
      failCount++;
    end

  // Every action is a single-cycle pulse
  actSingle: assert property (@(posedge clk) disable iff (i_reset) (act & $past(act)) == 5'd0)
    else begin
      $error("action pulse held for two cycles");
      failCount++;
    end

  errInAccess: assert property (@(posedge clk) disable iff (i_reset)
    i_apbRsp.pslverr |-> (i_apbReq.psel && i_apbReq.penable))
    else begin
      $error("pslverr outside an access phase");
      failCount++;
    end

endmodule

bind dfdTop dfdTop_checker chk_i (
  .clk       (clk),
  .i_reset   (i_reset),
  .i_apbReq  (i_apbReq),
  .i_apbRsp  (o_apbRsp),
  .i_actions (o_actions)
);
